/* vlog.f */
+incdir+.
io_scan_pkg.sv
io_bus_sequencer.sv
io_input_image.sv
io_host_port.sv
seg7_decoder.sv
io_scan_top.sv
io_board_model.sv
io_scan_sva.sv
tb_io_scan.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_io_scan -f vlog.f -o sim_tb_io_scan \
    && ./obj_dir/sim_tb_io_scan +verilator+error+limit+100 \
    || exit 1

/* tb_io_scan.sv */
`timescale 1ns/100ps
`include "io_scan_settings.svh"

module tb_io_scan
    import io_scan_pkg::*;
();

    localparam int SCAN_CYCLES     = 4 * `IO_INSTALLED_BOARDS;
    localparam int N_TRANS         = 300;
    localparam int WATCHDOG_CYCLES = N_TRANS * (SCAN_CYCLES + 20);

    // gfedcba, active high
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic       Clk = 1'b0;
    logic       reset;
    logic       req;
    logic       we;
    board_idx_t board;
    io_byte_t   wdata;
    io_byte_t   data_in;
    logic       ack;
    io_byte_t   rdata;
    logic [3:0] io_address;
    logic [1:0] io_enable_n;
    io_byte_t   data_out;
    logic       data_out_en;
    logic [6:0] seg_hi;
    logic [6:0] seg_lo;

    logic [`IO_BOARDS*`IO_DATA_W-1:0] in_flat;        // input byte of every board
    logic [`IO_BOARDS*`IO_DATA_W-1:0] board_latched;

    io_byte_t   model_out [`IO_BOARDS];
    io_byte_t   model_in  [`IO_BOARDS];
    io_byte_t   last_read;
    int         seed;

    logic       run_q;
    board_idx_t exp_board;
    logic       exp_read;
    logic       exp_strobe;
    io_byte_t   bus_byte;
    logic       capture_due;
    board_idx_t capture_idx;
    logic       write_due;
    board_idx_t write_idx;
    io_byte_t   write_val;

    always #20 Clk = ~Clk;

    io_scan_top dut0 (
        .Clk         (Clk),
        .reset       (reset),
        .req         (req),
        .we          (we),
        .board       (board),
        .wdata       (wdata),
        .data_in     (data_in),
        .ack         (ack),
        .rdata       (rdata),
        .io_address  (io_address),
        .io_enable_n (io_enable_n),
        .data_out    (data_out),
        .data_out_en (data_out_en),
        .seg_hi      (seg_hi),
        .seg_lo      (seg_lo)
    );

    io_board_model boards0 (
        .Clk         (Clk),
        .reset       (reset),
        .io_address  (io_address),
        .io_enable_n (io_enable_n),
        .data_out    (data_out),
        .data_out_en (data_out_en),
        .in_bytes    (in_flat),
        .data_in     (data_in),
        .latched     (board_latched)
    );

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            end_with_failure($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                       name, got, exp));
        end
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    task automatic set_input(input board_idx_t b, input io_byte_t v);
        in_flat[int'(b)*`IO_DATA_W +: `IO_DATA_W] = v;
    endtask

    // one four-phase handshake, req held for 1 + hold cycles after ack
    task automatic host_access(input logic wr, input board_idx_t b, input io_byte_t wd,
                               input io_byte_t exp_rd, input int hold);
        check_value("ack", 32'(ack), 32'd0);
        req   = 1'b1;
        we    = wr;
        board = b;
        wdata = wd;
        write_due = wr;                             // taken at the access edge
        write_idx = b;
        write_val = wd;
        @(negedge Clk);
        write_due = 1'b0;
        check_value("ack", 32'(ack), 32'd1);      // exactly one cycle after req
        if (!wr) begin
            check_value("rdata", 32'(rdata), 32'(exp_rd));
            last_read = exp_rd;
        end
        check_value("seg_hi", 32'(seg_hi), 32'(SEG_TABLE[last_read[7:4]]));
        check_value("seg_lo", 32'(seg_lo), 32'(SEG_TABLE[last_read[3:0]]));
        repeat (hold) begin
            @(negedge Clk);
            check_value("ack", 32'(ack), 32'd1);
            if (!wr) begin
                check_value("rdata", 32'(rdata), 32'(exp_rd));
            end
        end
        req = 1'b0;
        @(negedge Clk);
        check_value("ack", 32'(ack), 32'd0);      // one cycle after req drops
    endtask

    task automatic host_read(input board_idx_t b, input io_byte_t expected, input int hold);
        host_access(1'b0, b, 8'h00, expected, hold);
    endtask

    task automatic host_write(input board_idx_t b, input io_byte_t v, input int hold);
        host_access(1'b1, b, v, 8'h00, hold);
    endtask

    // board must hold the new byte within two full scans
    task automatic wait_delivery(input board_idx_t b);
        int       n;
        io_byte_t got;
        n   = 0;
        got = board_latched[int'(b)*`IO_DATA_W +: `IO_DATA_W];
        while (got !== model_out[b] && n < 2 * SCAN_CYCLES) begin
            @(negedge Clk);
            got = board_latched[int'(b)*`IO_DATA_W +: `IO_DATA_W];
            n++;
        end
        check_value("board_latched", 32'(got), 32'(model_out[b]));
    endtask

    // output image as the host port holds it
    always @(posedge Clk) begin : out_image_model
        if (!exp_strobe) begin
            bus_byte = model_out[exp_board];        // byte the setup edge puts on the bus
        end
        if (write_due) begin
            model_out[write_idx] = write_val;
        end
    end

    // input image as the read strobes fill it
    always @(posedge Clk) begin : input_model
        run_q <= ~reset;
        if (reset) begin
            for (int i = 0; i < `IO_BOARDS; i++) begin
                model_in[i] = '0;
            end
        end else if (capture_due) begin
            model_in[capture_idx] = in_flat[int'(capture_idx)*`IO_DATA_W +: `IO_DATA_W];
        end
    end

    // predicted slot order, setup then strobe
    always @(negedge Clk) begin : scan_monitor
        if (dut0.sva0.any_bad) begin
            end_with_failure("a bound assertion on the bus or the host handshake failed");
        end
        capture_due = 1'b0;
        if (run_q !== 1'b1) begin
            exp_board  = '0;
            exp_read   = 1'b0;
            exp_strobe = 1'b0;
        end else if (!exp_strobe) begin
            check_value("io_enable_n", 32'(io_enable_n), 32'(2'b11));
            check_value("io_address", 32'(io_address), 32'({exp_read, exp_board[2:0]}));
            check_value("data_out_en", 32'(data_out_en), 32'(!exp_read));
            if (!exp_read) begin
                check_value("data_out", 32'(data_out), 32'(bus_byte));
            end
            exp_strobe = 1'b1;
        end else begin
            check_value("io_enable_n", 32'(io_enable_n), 32'(exp_board[3] ? 2'b01 : 2'b10));
            check_value("io_address", 32'(io_address), 32'({exp_read, exp_board[2:0]}));
            check_value("data_out_en", 32'(data_out_en), 32'(!exp_read));
            if (!exp_read) begin
                check_value("data_out", 32'(data_out), 32'(bus_byte));
            end
            capture_due = exp_read;
            capture_idx = exp_board;
            exp_strobe  = 1'b0;
            if (!exp_read) begin
                exp_read = 1'b1;
            end else begin
                exp_read = 1'b0;
                if (int'(exp_board) == `IO_INSTALLED_BOARDS - 1) begin
                    exp_board = '0;
                end else begin
                    exp_board = exp_board + board_idx_t'(1);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge Clk);
        end_with_failure("watchdog expired before the host traffic finished");
    end

    initial begin : stimulus
        board_idx_t b;
        io_byte_t   v;
        logic       wr;
        seed      = 32'h1a9b_4684;
        reset     = 1'b1;
        req       = 1'b0;
        we        = 1'b0;
        board     = '0;
        wdata     = '0;
        in_flat   = '0;
        last_read = '0;
        write_due = 1'b0;
        write_idx = '0;
        write_val = '0;
        for (int i = 0; i < `IO_BOARDS; i++) begin
            model_out[i] = '0;
        end
        for (int i = 0; i < `IO_INSTALLED_BOARDS; i++) begin
            set_input(board_idx_t'(i), io_byte_t'(rand_below(255) + 1));   // never zero
        end
        repeat (5) @(negedge Clk);
        check_value("ack", 32'(ack), 32'd0);
        check_value("io_enable_n", 32'(io_enable_n), 32'(2'b11));
        check_value("data_out_en", 32'(data_out_en), 32'd0);
        check_value("seg_hi", 32'(seg_hi), 32'(SEG_TABLE[0]));
        check_value("seg_lo", 32'(seg_lo), 32'(SEG_TABLE[0]));
        reset = 1'b0;

        // reads ahead of the first capture
        host_read(board_idx_t'(`IO_INSTALLED_BOARDS - 1), 8'h00, 0);
        host_read(board_idx_t'(0), 8'h00, 0);
        host_read(board_idx_t'(`IO_BOARDS - 1), 8'h00, 0);

        for (int i = 0; i < `IO_INSTALLED_BOARDS; i++) begin
            b = board_idx_t'(i);
            v = io_byte_t'(rand_below(256));
            set_input(b, v);
            repeat (2 * SCAN_CYCLES) @(negedge Clk);
            host_read(b, v, 0);
        end

        for (int t = 0; t < N_TRANS; t++) begin
            if (rand_below(4) == 0) begin
                set_input(board_idx_t'(rand_below(`IO_INSTALLED_BOARDS)),
                          io_byte_t'(rand_below(256)));
            end
            b  = board_idx_t'(rand_below(`IO_INSTALLED_BOARDS));
            wr = (rand_below(2) == 1);
            if (wr) begin
                v = io_byte_t'(rand_below(256));
                host_write(b, v, rand_below(3));
                wait_delivery(b);
            end else begin
                host_read(b, model_in[b], rand_below(3));
            end
            repeat (rand_below(4)) @(negedge Clk);    // idle gap
        end

        if (dut0.sva0.any_bad == 1'b0) begin
            $display("all tests passed");
            $finish;
        end else begin
            end_with_failure("a bound assertion on the bus or the host handshake failed");
        end
    end

endmodule

/* io_scan_sva.sv */
`timescale 1ns/100ps

module io_scan_sva (
    input logic       Clk,
    input logic       reset,
    input logic       req,
    input logic       ack,
    input logic [1:0] io_enable_n
);

    logic bank_bad  = 1'b0;
    logic order_bad = 1'b0;
    logic rise_bad  = 1'b0;
    logic fall_bad  = 1'b0;
    logic any_bad;

    assign any_bad = bank_bad | order_bad | rise_bad | fall_bad;

    a_one_bank: assert property (@(posedge Clk) disable iff (reset)
        io_enable_n != 2'b00)
        else begin
            bank_bad = 1'b1;
            $error("both bank enables low in the same cycle");
        end

    // every strobe cycle comes right after a setup cycle
    a_setup_first: assert property (@(posedge Clk) disable iff (reset)
        (io_enable_n != 2'b11) |-> ($past(io_enable_n) == 2'b11))
        else begin
            order_bad = 1'b1;
            $error("bank enable strobe without a setup cycle before it");
        end

    a_ack_rise: assert property (@(posedge Clk) disable iff (reset)
        $rose(ack) |-> $past(req))
        else begin
            rise_bad = 1'b1;
            $error("ack rose without a pending req");
        end

    a_ack_fall: assert property (@(posedge Clk) disable iff (reset)
        $fell(ack) |-> !$past(req))
        else begin
            fall_bad = 1'b1;
            $error("ack fell while req was still high");
        end

endmodule

bind io_scan_top io_scan_sva sva0 (
    .Clk         (Clk),
    .reset       (reset),
    .req         (req),
    .ack         (ack),
    .io_enable_n (io_enable_n)
);

/* io_board_model.sv */
`timescale 1ns/100ps
`include "io_scan_settings.svh"

module io_board_model
    import io_scan_pkg::*;
(
    input  logic                             Clk,
    input  logic                             reset,
    input  logic [3:0]                       io_address,
    input  logic [1:0]                       io_enable_n,
    input  logic [`IO_DATA_W-1:0]            data_out,
    input  logic                             data_out_en,
    input  logic [`IO_BOARDS*`IO_DATA_W-1:0] in_bytes,
    output logic [`IO_DATA_W-1:0]            data_in,
    output logic [`IO_BOARDS*`IO_DATA_W-1:0] latched
);

    logic       strobe;
    logic       present;
    board_idx_t sel;

    assign strobe  = (io_enable_n != 2'b11);
    assign sel     = {~io_enable_n[1], io_address[2:0]};    // bank 1 low selects 8..15
    assign present = (int'(sel) < `IO_INSTALLED_BOARDS);

    // selected board answers a read strobe, bus idles at zero
    assign data_in = (strobe && !data_out_en && io_address[3] && present) ?
                     in_bytes[int'(sel)*`IO_DATA_W +: `IO_DATA_W] : '0;

    // output byte taken at the edge that ends the write strobe
    always_ff @(posedge Clk) begin
        if (reset) begin
            latched <= '0;
        end else if (strobe && data_out_en && !io_address[3] && present) begin
            latched[int'(sel)*`IO_DATA_W +: `IO_DATA_W] <= data_out;
        end
    end

endmodule

/* io_scan_top.sv */
`timescale 1ns/100ps
`include "io_scan_settings.svh"

module io_scan_top
    import io_scan_pkg::*;
(
    input  logic                  Clk,
    input  logic                  reset,
    input  logic                  req,
    input  logic                  we,
    input  board_idx_t            board,
    input  io_byte_t              wdata,
    input  logic [`IO_DATA_W-1:0] data_in,
    output logic                  ack,
    output io_byte_t              rdata,
    output logic [3:0]            io_address,
    output logic [1:0]            io_enable_n,
    output logic [`IO_DATA_W-1:0] data_out,
    output logic                  data_out_en,
    output logic [6:0]            seg_hi,
    output logic [6:0]            seg_lo
);

    logic [`IO_BOARDS*`IO_DATA_W-1:0] out_image;
    logic [`IO_BOARDS*`IO_DATA_W-1:0] in_image;
    logic                             capture;
    board_idx_t                       capture_board;
    io_byte_t                         rdata_latched;

    io_bus_sequencer u_seq (
        .Clk           (Clk),
        .reset         (reset),
        .out_image     (out_image),
        .io_address    (io_address),
        .io_enable_n   (io_enable_n),
        .data_out      (data_out),
        .data_out_en   (data_out_en),
        .capture       (capture),
        .capture_board (capture_board)
    );

    io_input_image u_in_img (
        .Clk           (Clk),
        .reset         (reset),
        .capture       (capture),
        .capture_board (capture_board),
        .data_in       (data_in),
        .in_image      (in_image)
    );

    io_host_port u_host (
        .Clk           (Clk),
        .reset         (reset),
        .req           (req),
        .we            (we),
        .board         (board),
        .wdata         (wdata),
        .in_image      (in_image),
        .ack           (ack),
        .rdata         (rdata),
        .out_image     (out_image),
        .rdata_latched (rdata_latched)
    );

    seg7_decoder u_seg_hi (
        .hex (rdata_latched[7:4]),      // upper digit
        .seg (seg_hi)
    );

    seg7_decoder u_seg_lo (
        .hex (rdata_latched[3:0]),
        .seg (seg_lo)
    );

endmodule

/* seg7_decoder.sv */
`timescale 1ns/100ps

module seg7_decoder (
    input  logic [3:0] hex,
    output logic [6:0] seg
);

    // active high, bit order gfedcba
    always_comb begin
        case (hex)
            4'h0:    seg = 7'b0111111;
            4'h1:    seg = 7'b0000110;
            4'h2:    seg = 7'b1011011;
            4'h3:    seg = 7'b1001111;
            4'h4:    seg = 7'b1100110;
            4'h5:    seg = 7'b1101101;
            4'h6:    seg = 7'b1111101;
            4'h7:    seg = 7'b0000111;
            4'h8:    seg = 7'b1111111;
            4'h9:    seg = 7'b1101111;
            4'hA:    seg = 7'b1110111;
            4'hB:    seg = 7'b1111100;   // lower case b
            4'hC:    seg = 7'b0111001;
            4'hD:    seg = 7'b1011110;   // lower case d
            4'hE:    seg = 7'b1111001;
            4'hF:    seg = 7'b1110001;
            default: seg = 7'b0000000;
        endcase
    end

endmodule

/* io_host_port.sv */
`timescale 1ns/100ps
`include "io_scan_settings.svh"

module io_host_port
    import io_scan_pkg::*;
(
    input  logic                             Clk,
    input  logic                             reset,
    input  logic                             req,
    input  logic                             we,
    input  board_idx_t                       board,
    input  io_byte_t                         wdata,
    input  logic [`IO_BOARDS*`IO_DATA_W-1:0] in_image,
    output logic                             ack,
    output io_byte_t                         rdata,
    output logic [`IO_BOARDS*`IO_DATA_W-1:0] out_image,
    output io_byte_t                         rdata_latched
);

    logic     access;
    io_byte_t in_byte;

    // one access per handshake, on the first cycle req is seen
    assign access  = req & ~ack;
    assign in_byte = in_image[board * `IO_DATA_W +: `IO_DATA_W];

    always_ff @(posedge Clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else if (access) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;                // drop one edge after req falls
        end
    end

    // output image, written for any board position
    always_ff @(posedge Clk) begin
        if (reset) begin
            out_image <= '0;
        end else if (access && we) begin
            out_image[board * `IO_DATA_W +: `IO_DATA_W] <= wdata;
        end
    end

    // read data for the host, echo of the new byte on writes
    always_ff @(posedge Clk) begin
        if (access) begin
            rdata <= we ? wdata : in_byte;
        end
    end

    // display copy, reads only
    always_ff @(posedge Clk) begin
        if (reset) begin
            rdata_latched <= '0;
        end else if (access && !we) begin
            rdata_latched <= in_byte;
        end
    end

endmodule

/* io_input_image.sv */
`timescale 1ns/100ps
`include "io_scan_settings.svh"

module io_input_image
    import io_scan_pkg::*;
(
    input  logic                              Clk,
    input  logic                              reset,
    input  logic                              capture,
    input  board_idx_t                        capture_board,
    input  io_byte_t                          data_in,
    output logic [`IO_BOARDS*`IO_DATA_W-1:0]  in_image
);

    io_byte_t regs [`IO_BOARDS];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < `IO_BOARDS; i++) begin
                regs[i] <= '0;                  // unread boards report zero
            end
        end else if (capture) begin
            regs[capture_board] <= data_in;     // edge that ends the read strobe
        end
    end

    // flatten for the host port
    for (genvar g = 0; g < `IO_BOARDS; g++) begin : g_flat
        assign in_image[g*`IO_DATA_W +: `IO_DATA_W] = regs[g];
    end

endmodule

/* io_bus_sequencer.sv */
`timescale 1ns/100ps
`include "io_scan_settings.svh"

module io_bus_sequencer
    import io_scan_pkg::*;
(
    input  logic                             Clk,
    input  logic                             reset,
    input  logic [`IO_BOARDS*`IO_DATA_W-1:0] out_image,
    output logic [3:0]                       io_address,
    output logic [1:0]                       io_enable_n,
    output logic [`IO_DATA_W-1:0]            data_out,
    output logic                             data_out_en,
    output logic                             capture,
    output board_idx_t                       capture_board
);

    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(2 * `IO_INSTALLED_BOARDS - 1);

    scan_slot_u slot;           // slot put on the bus at the next edge
    scan_slot_u slot_next;
    logic       strobe;         // next edge starts the strobe half
    io_byte_t   out_byte;

    always_comb begin
        out_byte = out_image[slot.f.board * `IO_DATA_W +: `IO_DATA_W];
        if (slot.count == LAST_SLOT) begin
            slot_next.count = '0;                       // wrap after last read slot
        end else begin
            slot_next.count = slot.count + SLOT_W'(1);
        end
    end

    // slot state and bus control
    always_ff @(posedge Clk) begin
        if (reset) begin
            slot.count  <= '0;
            strobe      <= 1'b0;
            io_enable_n <= 2'b11;
            data_out_en <= 1'b0;
            capture     <= 1'b0;
        end else begin
            strobe      <= ~strobe;
            data_out_en <= ~slot.f.read_phase;          // held over both halves
            capture     <= strobe & slot.f.read_phase;
            io_enable_n <= 2'b11;
            if (strobe) begin
                io_enable_n[slot.f.board[3]] <= 1'b0;  // bank of this board
                slot                         <= slot_next;
            end
        end
    end

    // address and data, stable across setup and strobe
    always_ff @(posedge Clk) begin
        capture_board <= slot.f.board;
        if (!strobe) begin
            io_address <= {slot.f.read_phase, slot.f.board[2:0]};
            data_out   <= out_byte;                     // sampled once per slot
        end
    end

endmodule

/* io_scan_pkg.sv */
`include "io_scan_settings.svh"

package io_scan_pkg;

    localparam int unsigned BOARD_W = $clog2(`IO_BOARDS);
    localparam int unsigned SLOT_W  = BOARD_W + 1;

    typedef logic [BOARD_W-1:0]    board_idx_t;
    typedef logic [`IO_DATA_W-1:0] io_byte_t;

    // one scan slot, counted as a whole or split into board and phase
    typedef union packed {
        logic [SLOT_W-1:0] count;       // raw slot number
        struct packed {
            board_idx_t board;          // upper bits
            logic       read_phase;     // 0 write slot, 1 read slot
        } f;
    } scan_slot_u;

endpackage

/* io_scan_settings.svh */
`ifndef IO_SCAN_SETTINGS_SVH
`define IO_SCAN_SETTINGS_SVH

// board positions on the backplane, sets the image sizes
`define IO_BOARDS 16

// populated positions, the scan covers 0 .. IO_INSTALLED_BOARDS-1
`define IO_INSTALLED_BOARDS 2

// shared bus width
`define IO_DATA_W 8

`endif
